//--- project.f
rtl/host_chan_pkg.sv
rtl/afu_csr_pkg.sv
rtl/mmio_csr_decode.sv
rtl/host_read_engine.sv
rtl/host_chan_events.sv
rtl/afu_result_mux.sv
rtl/host_chan_afu_top.sv
dv/tb_host_chan_afu.sv

//--- Makefile
# Verilator build and run of the host channel latency tester

TOP := tb_host_chan_afu
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard rtl/*.sv dv/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f project.f --top-module $(TOP) -o V$(TOP)

# The run passes only if the log holds the pass message
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timescale 1ns/1ps \
		$(shell grep '^rtl/' project.f) --top-module host_chan_afu_top
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_host_chan_afu.sv
// ================================================
// Testbench for the host channel latency tester.
// Host memory answers after 1 to 15 cycles, out of
// order; the model tracks in-flight reads at each
// falling edge, from the handshake at the next edge.
// ================================================

`default_nettype none

module tb_host_chan_afu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_outstanding = 8;
    localparam int read_timeout = 10;
    localparam int done_polls = 500;

    logic        clk;
    logic        rst_n;
    logic        mmio_wr_valid;
    logic        mmio_rd_valid;
    logic [7:0]  mmio_addr;
    logic [63:0] mmio_wr_data;
    logic        mmio_rd_data_valid;
    logic [63:0] mmio_rd_data;
    logic        rd_req_valid;
    logic [31:0] rd_req_addr;
    logic        rd_req_ready;
    logic        rd_rsp_valid;
    logic [63:0] rd_rsp_data;

    logic [31:0] lfsr_state = 32'h0e26_3956;
    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    // Reference model of the current run
    logic [31:0] cmd_base_model;
    logic [15:0] cmd_stride_model;
    int          req_index;
    int          model_in_flight = 0;
    int          peak_model;
    int          rsp_count_model;
    logic [63:0] lat_sum_model;
    logic [63:0] checksum_model;

    // Host memory holds one entry per accepted request
    logic [31:0] pend_addr[$];
    int          pend_delay[$];
    logic        new_req = 1'b0;
    logic [31:0] new_addr;

    host_chan_afu_top
    #(
        .max_outstanding(max_outstanding),
        .count_width(32)
    )
    dut
    (
        .clk,
        .rst_n,
        .mmio_wr_valid,
        .mmio_rd_valid,
        .mmio_addr,
        .mmio_wr_data,
        .mmio_rd_data_valid,
        .mmio_rd_data,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_ready,
        .rd_rsp_valid,
        .rd_rsp_data
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // ================================================
    // Helpers
    // ================================================

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Contents of host memory for one line
    function automatic logic [63:0] line_data(input logic [31:0] addr);
        return {addr ^ 32'h5a5a_c3c3, {addr[15:0], addr[31:16]} + 32'h1234_5678};
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic mmio_write(input afu_csr_pkg::t_csr_index index, input logic [63:0] data);
        @(posedge clk);
        #2;
        mmio_wr_valid = 1'b1;
        mmio_addr = {index, 3'b000};
        mmio_wr_data = data;
        @(posedge clk);
        #2;
        mmio_wr_valid = 1'b0;
    endtask

    // Counts falling edges after the edge that takes the request
    task automatic mmio_read(input afu_csr_pkg::t_csr_index index, output logic [63:0] data);
        int wait_cycles;
        data = 'x;
        @(posedge clk);
        #2;
        mmio_rd_valid = 1'b1;
        mmio_addr = {index, 3'b000};
        @(posedge clk);
        #2;
        mmio_rd_valid = 1'b0;
        wait_cycles = 0;
        do
        begin
            @(negedge clk);
            wait_cycles++;
        end
        while (mmio_rd_data_valid !== 1'b1 && wait_cycles < read_timeout);
        if (mmio_rd_data_valid !== 1'b1)
        begin
            timeouts++;
            $display("Timeout: no MMIO read data for register index %0d", index);
        end
        else
        begin
            check("mmio read latency", 64'(2), 64'(wait_cycles));
            data = mmio_rd_data;
        end
        #1;
    endtask

    task automatic wait_done(output logic [63:0] status);
        int polls;
        polls = 0;
        status = '0;
        while (polls < done_polls && timeouts == 0 &&
               status[afu_csr_pkg::status_done_bit] !== 1'b1)
        begin
            mmio_read(afu_csr_pkg::csr_status, status);
            polls++;
        end
        if (timeouts == 0 && status[afu_csr_pkg::status_done_bit] !== 1'b1)
        begin
            timeouts++;
            $display("Timeout: run did not finish after %0d status polls", polls);
        end
    endtask

    // ================================================
    // Host channel model
    // ================================================

    // Sees the values that the next rising edge will take
    task automatic observe_channel();
        logic fire;
        logic [31:0] exp_addr;
        fire = rd_req_valid && rd_req_ready;
        if (model_in_flight == max_outstanding)
            check("outstanding limit", 64'(0), 64'(rd_req_valid));
        lat_sum_model = lat_sum_model + 64'(model_in_flight);
        if (model_in_flight > peak_model)
            peak_model = model_in_flight;
        if (fire)
        begin
            exp_addr = cmd_base_model + 32'(cmd_stride_model) * 32'(req_index);
            check("request address", 64'(exp_addr), 64'(rd_req_addr));
            req_index++;
            new_req = 1'b1;
            new_addr = rd_req_addr;
        end
        if (rd_rsp_valid)
        begin
            checksum_model = checksum_model ^ rd_rsp_data;
            rsp_count_model++;
        end
        model_in_flight = model_in_flight + int'(fire) - int'(rd_rsp_valid);
    endtask

    // Oldest line whose delay has run out answers first
    task automatic drive_channel();
        int slot;
        slot = -1;
        rd_req_ready = (lfsr_bits(2) != 32'd0);
        foreach (pend_delay[i])
            pend_delay[i] = pend_delay[i] - 1;
        if (new_req)
        begin
            pend_addr.push_back(new_addr);
            pend_delay.push_back(1 + int'(lfsr_bits(4) % 32'd15));
            new_req = 1'b0;
        end
        foreach (pend_delay[i])
        begin
            if (slot < 0 && pend_delay[i] <= 0)
                slot = i;
        end
        rd_rsp_valid = (slot >= 0);
        rd_rsp_data = '0;
        if (slot >= 0)
        begin
            rd_rsp_data = line_data(pend_addr[slot]);
            pend_addr.delete(slot);
            pend_delay.delete(slot);
        end
    endtask

    initial
    begin
        forever
        begin
            @(negedge clk);
            if (rst_n)
                observe_channel();
            @(posedge clk);
            #2;
            drive_channel();
        end
    end

    // ================================================
    // Runs
    // ================================================

    // Called just after a falling edge while the channel is idle
    task automatic run_command(input logic [31:0] base, input logic [15:0] stride,
                               input logic [15:0] count);
        logic [63:0] word;
        logic [63:0] other;
        cmd_base_model = base;
        cmd_stride_model = stride;
        req_index = 0;
        peak_model = 0;
        rsp_count_model = 0;
        lat_sum_model = '0;
        checksum_model = '0;
        mmio_write(afu_csr_pkg::csr_cmd, {base, stride, count});
        mmio_read(afu_csr_pkg::csr_status, word);
        if (count == 16'd0)
        begin
            check("status after empty command",
                  64'(1) << afu_csr_pkg::status_done_bit, word);
        end
        else
        begin
            check("status during run", 64'(1) << afu_csr_pkg::status_busy_bit, word);
            // A second command while busy must leave the run alone
            other[63:32] = lfsr_bits(32);
            other[31:0] = lfsr_bits(32);
            mmio_write(afu_csr_pkg::csr_cmd, other);
            wait_done(word);
            check("status after run", 64'(1) << afu_csr_pkg::status_done_bit, word);
            // Done may only show once every read has been answered
            check("responses before done", 64'(count), 64'(rsp_count_model));
        end
        mmio_read(afu_csr_pkg::csr_checksum, word);
        check("checksum", checksum_model, word);
        mmio_read(afu_csr_pkg::csr_rsp_count, word);
        check("response count", 64'(rsp_count_model), word);
        mmio_read(afu_csr_pkg::csr_latency_sum, word);
        check("latency sum", lat_sum_model, word);
        mmio_read(afu_csr_pkg::csr_peak, word);
        check("peak in flight", 64'(peak_model), word);
        check("requests issued", 64'(count), 64'(req_index));
    endtask

    initial
    begin
        logic [63:0] word;
        logic [31:0] base;
        logic [15:0] stride;
        logic [15:0] count;
        rst_n = 1'b0;
        mmio_wr_valid = 1'b0;
        mmio_rd_valid = 1'b0;
        mmio_addr = '0;
        mmio_wr_data = '0;
        rd_req_ready = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_data = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mmio_read(afu_csr_pkg::csr_status, word);
        check("status after reset", 64'(0), word);
        run_command(32'h1234_5678, 16'h0003, 16'd0);
        // Both of these walk past the top of the address space
        run_command(32'hffff_fff0, 16'h0007, 16'd12);
        run_command(32'hfffe_0000, 16'hc001, 16'd20);

        for (int n = 0; n < 8; n++)
        begin
            if (timeouts == 0)
            begin
                base = lfsr_bits(32);
                stride = 16'(lfsr_bits(16));
                count = 16'(32'd8 + lfsr_bits(5));
                run_command(base, stride, count);
            end
        end

        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/host_chan_afu_top.sv
// ================================================
// Host channel read latency tester, single port and
// single clock. Responses carry no tag and may come
// back in any order, at most one per cycle.
// ================================================

`default_nettype none

module host_chan_afu_top
#(
    parameter int max_outstanding = 8,
    parameter int count_width = 32
)
(
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,

    // MMIO, no back-pressure, reads answer two cycles later
    input  wire logic                                        mmio_wr_valid,
    input  wire logic                                        mmio_rd_valid,
    input  wire logic [afu_csr_pkg::mmio_addr_width-1:0]     mmio_addr,
    input  wire afu_csr_pkg::t_mmio_word                     mmio_wr_data,
    output wire logic                                        mmio_rd_data_valid,
    output wire afu_csr_pkg::t_mmio_word                     mmio_rd_data,

    // Host read channel
    output wire logic                                        rd_req_valid,
    output wire host_chan_pkg::t_line_addr                   rd_req_addr,
    input  wire logic                                        rd_req_ready,
    input  wire logic                                        rd_rsp_valid,
    input  wire host_chan_pkg::t_line_data                   rd_rsp_data
);

    localparam int in_flight_width = $clog2(max_outstanding + 1);

    logic                                        start;
    host_chan_pkg::t_line_addr                   cmd_base;
    logic [afu_csr_pkg::cmd_field_width-1:0]     cmd_stride;
    logic [afu_csr_pkg::cmd_field_width-1:0]     cmd_count;
    logic                                        rd_sel_valid;
    afu_csr_pkg::t_csr_index                     rd_sel;

    logic                                        busy;
    logic                                        done;
    host_chan_pkg::t_line_data                   checksum;

    logic [in_flight_width-1:0]                  in_flight;
    logic [count_width-1:0]                      latency_sum;
    logic [count_width-1:0]                      rsp_count;
    logic [count_width-1:0]                      peak;

    // ================================================
    // Decode
    // ================================================

    mmio_csr_decode decode
    (
        .clk,
        .rst_n,
        .mmio_wr_valid,
        .mmio_rd_valid,
        .mmio_addr,
        .mmio_wr_data,
        .busy,
        .start,
        .cmd_base,
        .cmd_stride,
        .cmd_count,
        .rd_sel_valid,
        .rd_sel
    );

    // ================================================
    // Execute
    // ================================================

    host_read_engine
    #(
        .max_outstanding(max_outstanding)
    )
    engine
    (
        .clk,
        .rst_n,
        .start,
        .cmd_base,
        .cmd_stride,
        .cmd_count,
        .in_flight,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_ready,
        .rd_rsp_valid,
        .rd_rsp_data,
        .busy,
        .done,
        .checksum
    );

    host_chan_events
    #(
        .max_outstanding(max_outstanding),
        .count_width(count_width)
    )
    events
    (
        .clk,
        .rst_n,
        .start,
        .rd_req_valid,
        .rd_req_ready,
        .rd_rsp_valid,
        .in_flight,
        .latency_sum,
        .rsp_count,
        .peak
    );

    // ================================================
    // Result
    // ================================================

    afu_result_mux
    #(
        .count_width(count_width)
    )
    result
    (
        .clk,
        .rst_n,
        .rd_sel_valid,
        .rd_sel,
        .busy,
        .done,
        .checksum,
        .latency_sum,
        .rsp_count,
        .peak,
        .mmio_rd_data_valid,
        .mmio_rd_data
    );

endmodule

`default_nettype wire

//--- rtl/afu_result_mux.sv
// ================================================
// MMIO read-back, second of the two read stages.
// csr_cmd and unmapped indices read as zero.
// ================================================

`default_nettype none

module afu_result_mux
#(
    parameter int count_width = 32
)
(
    input  wire logic                           clk,
    input  wire logic                           rst_n,

    input  wire logic                           rd_sel_valid,
    input  wire afu_csr_pkg::t_csr_index        rd_sel,

    input  wire logic                           busy,
    input  wire logic                           done,
    input  wire host_chan_pkg::t_line_data      checksum,
    input  wire logic [count_width-1:0]         latency_sum,
    input  wire logic [count_width-1:0]         rsp_count,
    input  wire logic [count_width-1:0]         peak,

    output logic                                mmio_rd_data_valid,
    output afu_csr_pkg::t_mmio_word             mmio_rd_data
);

    afu_csr_pkg::t_mmio_word status_word;
    afu_csr_pkg::t_mmio_word sel_word;

    always_comb
    begin
        status_word = '0;
        status_word[afu_csr_pkg::status_busy_bit] = busy;
        status_word[afu_csr_pkg::status_done_bit] = done;
    end

    // Counters are zero-extended to the full MMIO word
    always_comb
    begin
        case (rd_sel)
            afu_csr_pkg::csr_status:      sel_word = status_word;
            afu_csr_pkg::csr_checksum:    sel_word = afu_csr_pkg::t_mmio_word'(checksum);
            afu_csr_pkg::csr_latency_sum: sel_word = afu_csr_pkg::t_mmio_word'(latency_sum);
            afu_csr_pkg::csr_rsp_count:   sel_word = afu_csr_pkg::t_mmio_word'(rsp_count);
            afu_csr_pkg::csr_peak:        sel_word = afu_csr_pkg::t_mmio_word'(peak);
            default:                      sel_word = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mmio_rd_data_valid <= 1'b0;
        else
            mmio_rd_data_valid <= rd_sel_valid;
    end

    always_ff @(posedge clk)
    begin
        mmio_rd_data <= sel_word;
    end

endmodule

`default_nettype wire

//--- rtl/host_chan_events.sv
// ================================================
// Host channel event tracker. The latency sum adds
// in_flight every cycle, so count_width must hold
// the longest run's total latency without wrapping.
// ================================================

`default_nettype none

module host_chan_events
#(
    parameter int max_outstanding = 8,
    parameter int count_width = 32
)
(
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,

    input  wire logic                                        start,
    input  wire logic                                        rd_req_valid,
    input  wire logic                                        rd_req_ready,
    input  wire logic                                        rd_rsp_valid,

    output logic [$clog2(max_outstanding + 1) - 1:0]         in_flight,
    output logic [count_width-1:0]                           latency_sum,
    output logic [count_width-1:0]                           rsp_count,
    output logic [count_width-1:0]                           peak
);

    logic req_fire;
    logic [count_width-1:0] in_flight_ext;

    assign req_fire      = rd_req_valid && rd_req_ready;
    assign in_flight_ext = count_width'(in_flight);

    // Request and response in one cycle cancel out
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            in_flight <= '0;
        else if (req_fire && !rd_rsp_valid)
            in_flight <= in_flight + 1'b1;
        else if (!req_fire && rd_rsp_valid)
            in_flight <= in_flight - 1'b1;
    end

    // ================================================
    // Per-run statistics
    // ================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n || start)
        begin
            latency_sum <= '0;
            rsp_count   <= '0;
            peak        <= '0;
        end
        else
        begin
            latency_sum <= latency_sum + in_flight_ext;
            if (rd_rsp_valid)
                rsp_count <= rsp_count + 1'b1;
            if (in_flight_ext > peak)
                peak <= in_flight_ext;
        end
    end

    a_limit: assert property (@(posedge clk) disable iff (!rst_n)
        int'(in_flight) <= max_outstanding);

    a_no_orphan_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rd_rsp_valid |-> (in_flight != '0));

endmodule

`default_nettype wire

//--- rtl/host_read_engine.sv
// ================================================
// Strided line read engine. Command inputs must stay
// stable while busy. in_flight comes from the event
// tracker and bounds the requests in flight.
// ================================================

`default_nettype none

module host_read_engine
#(
    parameter int max_outstanding = 8
)
(
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,

    input  wire logic                                        start,
    input  wire host_chan_pkg::t_line_addr                   cmd_base,
    input  wire logic [afu_csr_pkg::cmd_field_width-1:0]     cmd_stride,
    input  wire logic [afu_csr_pkg::cmd_field_width-1:0]     cmd_count,
    input  wire logic [$clog2(max_outstanding + 1) - 1:0]    in_flight,

    output logic                                             rd_req_valid,
    output host_chan_pkg::t_line_addr                        rd_req_addr,
    input  wire logic                                        rd_req_ready,

    input  wire logic                                        rd_rsp_valid,
    input  wire host_chan_pkg::t_line_data                   rd_rsp_data,

    output logic                                             busy,
    output logic                                             done,
    output host_chan_pkg::t_line_data                        checksum
);

    logic [afu_csr_pkg::cmd_field_width-1:0] issued;
    logic all_issued;
    logic below_limit;
    logic req_fire;

    assign all_issued  = (issued == cmd_count);
    assign below_limit = (int'(in_flight) < max_outstanding);

    // in_flight only grows on a transfer, so a waiting request keeps valid
    assign rd_req_valid = busy && !all_issued && below_limit;
    assign req_fire     = rd_req_valid && rd_req_ready;

    // ================================================
    // Run control
    // ================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy   <= 1'b0;
            done   <= 1'b0;
            issued <= '0;
        end
        else if (start)
        begin
            issued <= '0;
            // Empty command finishes right away
            busy   <= (cmd_count != '0);
            done   <= (cmd_count == '0);
        end
        else
        begin
            if (req_fire)
                issued <= issued + 1'b1;

            // Finished once everything is issued and answered
            if (busy && all_issued && (in_flight == '0))
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // ================================================
    // Address walk, wraps modulo 2^addr_width
    // ================================================

    always_ff @(posedge clk)
    begin
        if (start)
            rd_req_addr <= cmd_base;
        else if (req_fire)
            rd_req_addr <= rd_req_addr + host_chan_pkg::t_line_addr'(cmd_stride);
    end

    // Response order does not matter for an XOR fold
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            checksum <= '0;
        else if (start)
            checksum <= '0;
        else if (rd_rsp_valid)
            checksum <= checksum ^ rd_rsp_data;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr));

endmodule

`default_nettype wire

//--- rtl/mmio_csr_decode.sv
// ================================================
// MMIO decode. Writes and reads share mmio_addr, so
// a write and a read request must not arrive in the
// same cycle. Command writes while busy are dropped.
// ================================================

`default_nettype none

module mmio_csr_decode
(
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,

    input  wire logic                                        mmio_wr_valid,
    input  wire logic                                        mmio_rd_valid,
    input  wire logic [afu_csr_pkg::mmio_addr_width-1:0]     mmio_addr,
    input  wire afu_csr_pkg::t_mmio_word                     mmio_wr_data,

    input  wire logic                                        busy,

    output logic                                             start,
    output host_chan_pkg::t_line_addr                        cmd_base,
    output logic [afu_csr_pkg::cmd_field_width-1:0]          cmd_stride,
    output logic [afu_csr_pkg::cmd_field_width-1:0]          cmd_count,

    output logic                                             rd_sel_valid,
    output afu_csr_pkg::t_csr_index                          rd_sel
);

    afu_csr_pkg::t_csr_word   wr_word;
    afu_csr_pkg::t_csr_index  addr_index;
    logic                     cmd_load;

    assign wr_word.raw = mmio_wr_data;
    assign addr_index = mmio_addr[afu_csr_pkg::mmio_addr_width-1:3];

    // A start already in flight counts as busy, busy is one cycle behind it
    assign cmd_load = mmio_wr_valid && (addr_index == afu_csr_pkg::csr_cmd) &&
                      !busy && !start;

    // ================================================
    // Command registers and start pulse
    // ================================================

    always_ff @(posedge clk)
    begin
        if (cmd_load)
        begin
            cmd_base   <= wr_word.cmd.base;
            cmd_stride <= wr_word.cmd.stride;
            cmd_count  <= wr_word.cmd.count;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            start <= 1'b0;
        else
            start <= cmd_load;
    end

    // ================================================
    // Read select, first of the two read stages
    // ================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_sel_valid <= 1'b0;
        else
            rd_sel_valid <= mmio_rd_valid;
    end

    always_ff @(posedge clk)
    begin
        rd_sel <= addr_index;
    end

    // Engine must be idle whenever a new run is launched
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy);

endmodule

`default_nettype wire

//--- rtl/afu_csr_pkg.sv
// ================================================
// MMIO register map of the latency tester. Registers
// are 64 bits wide on 8-byte boundaries, so the low
// three address bits are ignored.
// ================================================

`default_nettype none

package afu_csr_pkg;

    localparam int mmio_addr_width = 8;
    localparam int mmio_data_width = 64;
    localparam int csr_index_width = mmio_addr_width - 3;
    localparam int cmd_field_width = 16;

    typedef logic [mmio_data_width-1:0] t_mmio_word;
    typedef logic [csr_index_width-1:0] t_csr_index;

    // ================================================
    // Register indices (byte address / 8)
    // ================================================

    localparam t_csr_index csr_cmd         = t_csr_index'(0);
    localparam t_csr_index csr_status      = t_csr_index'(1);
    localparam t_csr_index csr_checksum    = t_csr_index'(2);
    localparam t_csr_index csr_latency_sum = t_csr_index'(3);
    localparam t_csr_index csr_rsp_count   = t_csr_index'(4);
    localparam t_csr_index csr_peak        = t_csr_index'(5);

    // Status word layout
    localparam int status_busy_bit = 0;
    localparam int status_done_bit = 1;

    // ================================================
    // Command word
    // ================================================

    // Base in the upper half, count in the lowest bits
    typedef struct packed {
        host_chan_pkg::t_line_addr   base;
        logic [cmd_field_width-1:0]  stride;
        logic [cmd_field_width-1:0]  count;
    } t_csr_cmd;

    typedef union packed {
        t_csr_cmd    cmd;
        t_mmio_word  raw;
    } t_csr_word;

endpackage

`default_nettype wire

//--- rtl/host_chan_pkg.sv
// ================================================
// Host channel widths shared by the engine, the
// event tracker and the top level. One address
// names one full line; byte offsets are not used.
// ================================================

`default_nettype none

package host_chan_pkg;

    // ================================================
    // Widths
    // ================================================

    // Line address, counted in lines and not in bytes
    localparam int addr_width = 32;

    // One response word per line read
    localparam int data_width = 64;

    // ================================================
    // Types
    // ================================================

    typedef logic [addr_width-1:0] t_line_addr;

    typedef logic [data_width-1:0] t_line_data;

endpackage

`default_nettype wire
